// ==== hw/trace_pkg.sv ====
// trace matcher shared definitions
package trace_pkg;

  // sizes
  localparam int BUFFER_BITS = 64;   // trace history length
  localparam int NIBBLE_BITS = 4;    // trace sample width
  localparam int MATCH_RULES = 8;
  localparam int REG_BITS    = 8;    // register port byte

  // register address split for pattern and mask regions
  localparam int BYTE_BITS = $clog2(BUFFER_BITS / REG_BITS);
  localparam int RULE_BITS = $clog2(MATCH_RULES);

  typedef logic [BUFFER_BITS-1:0] buffer_t;   // history, pattern or mask
  typedef logic [MATCH_RULES-1:0] rule_vec_t; // one bit per rule
  typedef logic [7:0]             count_t;
  typedef logic [REG_BITS-1:0]    reg_addr_t;
  typedef logic [REG_BITS-1:0]    reg_data_t;
  typedef logic [NIBBLE_BITS-1:0] nibble_t;

  localparam count_t COUNT_MAX = 8'd255;      // counters stick here

  // register map
  // pattern and mask bytes sit at rule*8 + byte, byte 0 least significant
  localparam reg_addr_t ADDR_PATTERN_BASE   = 8'h00;
  localparam reg_addr_t ADDR_MASK_BASE      = 8'h40;
  localparam reg_addr_t ADDR_PATTERN_ENABLE = 8'h80;
  localparam reg_addr_t ADDR_TRIG_ENABLE    = 8'h81;
  localparam reg_addr_t ADDR_CONTROL        = 8'h82;  // bit 0 clears counters
  localparam reg_addr_t ADDR_COUNT_BASE     = 8'h88;  // one byte per rule
  localparam reg_addr_t ADDR_MATCHED_BASE   = 8'h90;  // eight bytes, lsb first

endpackage

// ==== hw/match_cfg_if.sv ====
// match rule configuration bus
`timescale 1ns/10ps

interface match_cfg_if import trace_pkg::*; ();

  buffer_t   [MATCH_RULES-1:0] patterns;  // compare values per rule
  buffer_t   [MATCH_RULES-1:0] masks;     // one = bit is compared
  rule_vec_t                   pattern_enable;

  // register block side
  modport cfg_src (
    output patterns,
    output masks,
    output pattern_enable
  );

  // matcher side
  modport cfg_dst (
    input patterns,
    input masks,
    input pattern_enable
  );

endinterface

// ==== hw/reg_decode.sv ====
// register decode and rule storage
`timescale 1ns/10ps

module reg_decode import trace_pkg::*; (
  input  logic                     fe_clk,
  input  logic                     reset,
  input  logic                     reg_write,
  input  logic                     reg_read,
  input  reg_addr_t                reg_address,
  input  reg_data_t                write_data,
  output reg_data_t                read_data,
  match_cfg_if.cfg_src             cfg,
  output rule_vec_t                trig_enable,
  output logic                     clear_counts,
  input  count_t [MATCH_RULES-1:0] counts,
  input  buffer_t                  matched_data
);

  logic [RULE_BITS-1:0]   rule_sel;   // rule within pattern or mask region
  logic [BYTE_BITS-1:0]   byte_sel;
  logic [BYTE_BITS+2:0]   bit_sel;    // lsb of the addressed byte
  logic [RULE_BITS-1:0]   slot_sel;   // rule within count region
  logic                   pattern_sel;
  logic                   mask_sel;
  logic                   count_sel;
  logic                   matched_sel;
  reg_data_t              read_mux;

  assign rule_sel = reg_address[BYTE_BITS +: RULE_BITS];
  assign byte_sel = reg_address[BYTE_BITS-1:0];
  assign bit_sel  = {byte_sel, 3'b000};
  assign slot_sel = reg_address[RULE_BITS-1:0];

  // region decode on the upper address bits
  assign pattern_sel = reg_address[7:6] == ADDR_PATTERN_BASE[7:6];
  assign mask_sel    = reg_address[7:6] == ADDR_MASK_BASE[7:6];
  assign count_sel   = reg_address[7:3] == ADDR_COUNT_BASE[7:3];
  assign matched_sel = reg_address[7:3] == ADDR_MATCHED_BASE[7:3];

  // counters clear on the same edge that samples the write
  assign clear_counts = reg_write && (reg_address == ADDR_CONTROL) && write_data[0];

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      cfg.patterns       <= '0;
      cfg.masks          <= '0;
      cfg.pattern_enable <= '0;
      trig_enable        <= '0;
    end else if (reg_write) begin
      if (pattern_sel)
        cfg.patterns[rule_sel][bit_sel +: REG_BITS] <= write_data;
      if (mask_sel)
        cfg.masks[rule_sel][bit_sel +: REG_BITS] <= write_data;
      if (reg_address == ADDR_PATTERN_ENABLE)
        cfg.pattern_enable <= write_data;
      if (reg_address == ADDR_TRIG_ENABLE)
        trig_enable <= write_data;
    end
  end

  // read map, anything unmapped gives zero
  always_comb begin
    read_mux = '0;
    if (pattern_sel)
      read_mux = cfg.patterns[rule_sel][bit_sel +: REG_BITS];
    else if (mask_sel)
      read_mux = cfg.masks[rule_sel][bit_sel +: REG_BITS];
    else if (count_sel)
      read_mux = counts[slot_sel];
    else if (matched_sel)
      read_mux = matched_data[bit_sel +: REG_BITS];
    else if (reg_address == ADDR_PATTERN_ENABLE)
      read_mux = cfg.pattern_enable;
    else if (reg_address == ADDR_TRIG_ENABLE)
      read_mux = trig_enable;
  end

  always_ff @(posedge fe_clk) begin
    if (reset)
      read_data <= '0;
    else if (reg_read)
      read_data <= read_mux;  // valid the cycle after the read
  end

  // host side never issues both strobes at once
  read_write_exclusive: assert property (
    @(posedge fe_clk) disable iff (reset) !(reg_read && reg_write)
  );

endmodule

// ==== hw/pattern_match.sv ====
// trace history and masked compare
`timescale 1ns/10ps

module pattern_match import trace_pkg::*; (
  input  logic          fe_clk,
  input  logic          reset,
  input  logic          trace_valid,
  input  nibble_t       trace_data,
  match_cfg_if.cfg_dst  cfg,
  output logic          match_valid,
  output rule_vec_t     match_hits,
  output buffer_t       match_buffer
);

  buffer_t   history;   // newest nibble in the low bits
  logic      shifted;   // history changed on the last edge
  rule_vec_t hits;

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      history <= '0;
      shifted <= 1'b0;
    end else begin
      shifted <= trace_valid;
      if (trace_valid)
        history <= {history[BUFFER_BITS-NIBBLE_BITS-1:0], trace_data};
    end
  end

  // a rule hits when every masked bit equals its pattern bit
  always_comb begin
    for (int r = 0; r < MATCH_RULES; r++) begin
      hits[r] = cfg.pattern_enable[r] &&
                (((history ^ cfg.patterns[r]) & cfg.masks[r]) == '0);
    end
  end

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      match_valid <= 1'b0;
      match_hits  <= '0;
    end else begin
      match_valid <= shifted;
      match_hits  <= shifted ? hits : '0;
    end
  end

  always_ff @(posedge fe_clk) begin
    match_buffer <= history;  // snapshot that goes with match_hits
  end

  // hits come from the enable seen one cycle before they are presented
  hits_only_enabled: assert property (
    @(posedge fe_clk) disable iff (reset)
    (match_hits & ~$past(cfg.pattern_enable)) == '0
  );

endmodule

// ==== hw/match_result.sv ====
// match counters and trigger
`timescale 1ns/10ps

module match_result import trace_pkg::*; (
  input  logic                     fe_clk,
  input  logic                     reset,
  input  logic                     match_valid,
  input  rule_vec_t                match_hits,
  input  buffer_t                  match_buffer,
  input  rule_vec_t                trig_enable,
  input  logic                     clear_counts,
  output count_t [MATCH_RULES-1:0] counts,
  output buffer_t                  matched_data,
  output logic                     trig_out
);

  logic trig_hit;

  // at least one trigger-enabled rule hit in this compare
  assign trig_hit = match_valid && ((match_hits & trig_enable) != '0);

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      counts <= '0;
    end else if (clear_counts) begin
      counts <= '0;           // clear wins over counting
    end else if (match_valid) begin
      for (int r = 0; r < MATCH_RULES; r++) begin
        if (match_hits[r] && (counts[r] != COUNT_MAX))
          counts[r] <= counts[r] + 8'd1;
      end
    end
  end

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      trig_out     <= 1'b0;
      matched_data <= '0;
    end else begin
      trig_out <= trig_hit;   // one cycle per triggering compare
      if (trig_hit)
        matched_data <= match_buffer;
    end
  end

  // a trigger always follows a compare result
  trig_after_valid: assert property (
    @(posedge fe_clk) disable iff (reset) trig_out |-> $past(match_valid)
  );

endmodule

// ==== hw/trace_matcher.sv ====
// trace pattern matcher top
`timescale 1ns/10ps

module trace_matcher import trace_pkg::*; (
  input  logic      fe_clk,
  input  logic      reset,
  input  logic      trace_valid,
  input  nibble_t   trace_data,
  input  logic      reg_write,
  input  logic      reg_read,
  input  reg_addr_t reg_address,
  input  reg_data_t write_data,
  output reg_data_t read_data,
  output logic      trig_out
);

  rule_vec_t                trig_enable;
  logic                     clear_counts;
  logic                     match_valid;
  rule_vec_t                match_hits;
  buffer_t                  match_buffer;
  count_t [MATCH_RULES-1:0] counts;
  buffer_t                  matched_data;

  match_cfg_if cfg_bus ();  // rule config from registers to matcher

  reg_decode u_reg_decode (
    .fe_clk       (fe_clk),
    .reset        (reset),
    .reg_write    (reg_write),
    .reg_read     (reg_read),
    .reg_address  (reg_address),
    .write_data   (write_data),
    .read_data    (read_data),
    .cfg          (cfg_bus.cfg_src),
    .trig_enable  (trig_enable),
    .clear_counts (clear_counts),
    .counts       (counts),
    .matched_data (matched_data)
  );

  pattern_match u_pattern_match (
    .fe_clk       (fe_clk),
    .reset        (reset),
    .trace_valid  (trace_valid),
    .trace_data   (trace_data),
    .cfg          (cfg_bus.cfg_dst),
    .match_valid  (match_valid),
    .match_hits   (match_hits),
    .match_buffer (match_buffer)
  );

  match_result u_match_result (
    .fe_clk       (fe_clk),
    .reset        (reset),
    .match_valid  (match_valid),
    .match_hits   (match_hits),
    .match_buffer (match_buffer),
    .trig_enable  (trig_enable),
    .clear_counts (clear_counts),
    .counts       (counts),
    .matched_data (matched_data),
    .trig_out     (trig_out)
  );

endmodule

// ==== verification/tb_clock.sv ====
// testbench clock and reset
`timescale 1ns/10ps

module tb_clock #(
  parameter int PERIOD       = 4,
  parameter int RESET_CYCLES = 5
) (
  output logic fe_clk,
  output logic reset
);

  initial begin
    fe_clk = 1'b0;
    forever #(PERIOD / 2) fe_clk = ~fe_clk;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge fe_clk);
    reset <= 1'b0;  // released right after an edge
  end

endmodule

// ==== verification/tb_trace_matcher.sv ====
// trace matcher testbench
`timescale 1ns/10ps

module tb_trace_matcher import trace_pkg::*;;

  localparam int CLK_PERIOD  = 4;
  localparam int MAP_SPAN    = 'h98;   // every mapped byte address
  localparam int RW_CHECKS   = 32;
  localparam int STREAM_LEN  = 400;
  localparam int TEST_CYCLES = 2 * (2 * MAP_SPAN + 2 * RW_CHECKS + 16 * MATCH_RULES + 19)
                               + STREAM_LEN + 20;

  logic      fe_clk;
  logic      reset;
  logic      trace_valid;
  nibble_t   trace_data;
  logic      reg_write;
  logic      reg_read;
  reg_addr_t reg_address;
  reg_data_t write_data;
  reg_data_t read_data;
  logic      trig_out;

  // reference state
  buffer_t   model_pattern [MATCH_RULES];
  buffer_t   model_mask [MATCH_RULES];
  count_t    model_count [MATCH_RULES];
  buffer_t   model_buffer;
  buffer_t   model_matched;
  rule_vec_t model_pen;
  rule_vec_t model_ten;

  logic        exp_trig_d1;
  logic        exp_trig_d2;
  logic        exp_trig_d3;   // lines up with trig_out
  logic        read_pending;
  reg_addr_t   read_addr;
  reg_data_t   read_expect;
  logic [31:0] rng_state;
  int          trig_total;
  int          trig_errors;
  int          read_errors;
  int          other_errors;

  tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) clock_gen (
    .fe_clk (fe_clk),
    .reset  (reset)
  );

  trace_matcher dut (
    .fe_clk      (fe_clk),
    .reset       (reset),
    .trace_valid (trace_valid),
    .trace_data  (trace_data),
    .reg_write   (reg_write),
    .reg_read    (reg_read),
    .reg_address (reg_address),
    .write_data  (write_data),
    .read_data   (read_data),
    .trig_out    (trig_out)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // register map as the host sees it
  function automatic reg_data_t expected_read(input reg_addr_t addr);
    int a;
    a = int'(addr);
    if (a < int'(ADDR_MASK_BASE))
      return model_pattern[(a / 8) % 8][(a % 8) * 8 +: 8];
    if (a < int'(ADDR_PATTERN_ENABLE))
      return model_mask[(a / 8) % 8][(a % 8) * 8 +: 8];
    if (a == int'(ADDR_PATTERN_ENABLE))
      return model_pen;
    if (a == int'(ADDR_TRIG_ENABLE))
      return model_ten;
    if (a >= int'(ADDR_COUNT_BASE) && a < int'(ADDR_COUNT_BASE) + MATCH_RULES)
      return model_count[a % 8];
    if (a >= int'(ADDR_MATCHED_BASE) && a < int'(ADDR_MATCHED_BASE) + 8)
      return model_matched[(a % 8) * 8 +: 8];
    return '0;  // unmapped
  endfunction

  function automatic void apply_write(input reg_addr_t addr, input reg_data_t data);
    int a;
    a = int'(addr);
    if (a < int'(ADDR_MASK_BASE))
      model_pattern[(a / 8) % 8][(a % 8) * 8 +: 8] = data;
    else if (a < int'(ADDR_PATTERN_ENABLE))
      model_mask[(a / 8) % 8][(a % 8) * 8 +: 8] = data;
    else if (a == int'(ADDR_PATTERN_ENABLE))
      model_pen = data;
    else if (a == int'(ADDR_TRIG_ENABLE))
      model_ten = data;
    else if (a == int'(ADDR_CONTROL) && data[0]) begin
      for (int r = 0; r < MATCH_RULES; r++)
        model_count[r] = '0;
    end
  endfunction

  // one strobed nibble, returns whether a trigger follows
  function automatic logic model_step(input nibble_t nib);
    logic fire;
    fire = 1'b0;
    model_buffer = {model_buffer[BUFFER_BITS-NIBBLE_BITS-1:0], nib};
    for (int r = 0; r < MATCH_RULES; r++) begin
      if (model_pen[r] && ((model_buffer ^ model_pattern[r]) & model_mask[r]) == '0) begin
        if (model_count[r] != COUNT_MAX)
          model_count[r] = model_count[r] + 8'd1;
        if (model_ten[r])
          fire = 1'b1;
      end
    end
    if (fire)
      model_matched = model_buffer;
    return fire;
  endfunction

  // follows what the DUT samples on each edge
  always @(posedge fe_clk) begin
    if (reset) begin
      exp_trig_d1  = 1'b0;
      exp_trig_d2  = 1'b0;
      exp_trig_d3  = 1'b0;
      read_pending = 1'b0;
    end else begin
      read_pending = reg_read;
      if (reg_read) begin
        read_addr   = reg_address;
        read_expect = expected_read(reg_address);
      end
      if (reg_write)
        apply_write(reg_address, write_data);
      exp_trig_d3 = exp_trig_d2;
      exp_trig_d2 = exp_trig_d1;
      exp_trig_d1 = 1'b0;
      if (trace_valid)
        exp_trig_d1 = model_step(trace_data);
      if (exp_trig_d1)
        trig_total++;
    end
  end

  always @(negedge fe_clk) begin
    if (!reset) begin
      assert (trig_out === exp_trig_d3) else begin
        trig_errors++;
        $display("error: trig_out is 0x%0h, expected 0x%0h at %0t", trig_out, exp_trig_d3,
                 $time);
      end
      if (read_pending) begin
        assert (read_data === read_expect) else begin
          read_errors++;
          $display("error: read_data at 0x%02h is 0x%02h, expected 0x%02h", read_addr,
                   read_data, read_expect);
        end
      end
    end
  end

  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    @(posedge fe_clk);
    reg_write   <= 1'b1;
    reg_address <= addr;
    write_data  <= data;
    @(posedge fe_clk);
    reg_write   <= 1'b0;
  endtask

  task automatic read_reg(input reg_addr_t addr);
    @(posedge fe_clk);
    reg_read    <= 1'b1;
    reg_address <= addr;
    @(posedge fe_clk);
    reg_read    <= 1'b0;
  endtask

  task automatic read_range(input int first, input int last);
    for (int a = first; a <= last; a++)
      read_reg(reg_addr_t'(a));
  endtask

  task automatic write_word(input reg_addr_t base, input int rule, input buffer_t value);
    for (int b = 0; b < 8; b++)
      write_reg(reg_addr_t'(int'(base) + rule * 8 + b), value[b * 8 +: 8]);
  endtask

  initial begin : watchdog
    #((TEST_CYCLES + 100) * CLK_PERIOD);
    $display("timeout, the tests did not finish within %0d cycles", TEST_CYCLES + 100);
    $display("Regression failed");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] rnd;
    logic [31:0] rnd_b;
    logic [31:0] rnd_c;
    logic [15:0] m16;
    reg_addr_t   addr;
    trace_valid  = 1'b0;
    trace_data   = '0;
    reg_write    = 1'b0;
    reg_read     = 1'b0;
    reg_address  = '0;
    write_data   = '0;
    rng_state    = 32'h61bc;
    model_buffer = '0;
    model_matched = '0;
    model_pen    = '0;
    model_ten    = '0;
    for (int r = 0; r < MATCH_RULES; r++) begin
      model_pattern[r] = '0;
      model_mask[r]    = '0;
      model_count[r]   = '0;
    end
    trig_total   = 0;
    trig_errors  = 0;
    read_errors  = 0;
    other_errors = 0;
    @(negedge reset);

    read_range(0, MAP_SPAN - 1);  // everything zero after reset

    // random config bytes, each read straight back
    for (int i = 0; i < RW_CHECKS; i++) begin
      rnd  = next_rand();
      addr = (rnd[15:13] == 3'd0) ? {7'h40, rnd[8]} : {1'b0, rnd[6:0]};
      write_reg(addr, rnd[23:16]);
      read_reg(addr);
    end

    // random patterns, sparse masks, rule 0 compares nothing
    for (int r = 0; r < MATCH_RULES; r++) begin
      rnd   = next_rand();
      rnd_b = next_rand();
      rnd_c = next_rand();
      m16   = (r == 0) ? 16'h0 : rnd[15:0] & rnd_b[15:0] & rnd_c[15:0];
      write_word(ADDR_PATTERN_BASE, r, {rnd_b, rnd});
      write_word(ADDR_MASK_BASE, r, buffer_t'(m16) << (int'(rnd_c[19:16]) * 3));
    end
    rnd = next_rand();
    write_reg(ADDR_PATTERN_ENABLE, rnd[7:0] | 8'h03);
    write_reg(ADDR_TRIG_ENABLE, (rnd[15:8] & 8'hfe) | 8'h02);

    for (int i = 0; i < STREAM_LEN; i++) begin
      rnd = next_rand();
      @(posedge fe_clk);
      trace_valid <= rnd[0] | rnd[1];  // about three strobes in four
      trace_data  <= rnd[7:4];
    end
    @(posedge fe_clk);
    trace_valid <= 1'b0;
    repeat (4) @(posedge fe_clk);

    assert (trig_total > 0) else begin
      other_errors++;
      $display("the trace stream never produced a trigger");
    end
    assert (model_count[0] == COUNT_MAX) else begin
      other_errors++;
      $display("rule 0 did not reach saturation during the stream");
    end

    read_range(int'(ADDR_COUNT_BASE), int'(ADDR_COUNT_BASE) + MATCH_RULES - 1);
    read_range(int'(ADDR_MATCHED_BASE), int'(ADDR_MATCHED_BASE) + 7);

    write_reg(ADDR_CONTROL, 8'h01);
    read_range(0, MAP_SPAN - 1);  // counters zero, the rest kept

    repeat (4) @(posedge fe_clk);
    $display("checks done, trig errors %0d, read errors %0d, other errors %0d",
             trig_errors, read_errors, other_errors);
    if (trig_errors + read_errors + other_errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// ==== trace_matcher.f ====
hw/trace_pkg.sv
hw/match_cfg_if.sv
hw/reg_decode.sv
hw/pattern_match.sv
hw/match_result.sv
hw/trace_matcher.sv
verification/tb_clock.sv
verification/tb_trace_matcher.sv

// ==== Makefile ====
TOP := tb_trace_matcher

all: run

obj_dir/V$(TOP): trace_matcher.f $(wildcard hw/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f trace_matcher.f

run: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module trace_matcher -f trace_matcher.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
